//--- rtl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b                              // lui passes the immediate through.
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu
    } branch_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc_plus4,
        wb_csr
    } wb_sel_e;

    typedef enum logic [1:0] {
        csr_none,
        csr_write,
        csr_set
    } csr_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    src_a_pc;                      // operand a is the pc.
        logic    src_b_imm;                     // operand b is the immediate.
        branch_e branch;
        logic    jump;
        logic    reg_wen;
        logic    mem_ren;
        logic    mem_wen;
        wb_sel_e wb_sel;
        csr_op_e csr_op;
        logic    ecall;
        logic    mret;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic        wen;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dmem_req_t;

    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;

    localparam logic [31:0] mstatus_reset = 32'h0000_1800;  // mpp set to machine mode.
    localparam logic [31:0] mcause_ecall  = 32'd11;          // ecall from m-mode.

endpackage

`default_nettype wire

//--- rtl/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import rv_core_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h8000_0000
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire ctrl_t  ctrl,
    input  wire  [31:0] imm,
    input  wire         taken,
    input  wire  [31:0] alu_result,
    input  wire  [31:0] mepc,
    input  wire  [31:0] mtvec,
    output logic [31:0] pc,
    output logic        halt
);

    logic [31:0] next_pc;

    always_comb begin
        if (ctrl.halt) begin
            next_pc = pc;                       // ebreak parks the pc on itself.
        end else if (ctrl.mret) begin
            next_pc = mepc;
        end else if (ctrl.ecall) begin
            next_pc = mtvec;
        end else if (ctrl.jump) begin
            next_pc = {alu_result[31:1], 1'b0}; // jal and jalr targets come from the alu.
        end else if (taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc   <= reset_pc;
            halt <= 1'b0;
        end else if (!halt) begin
            pc   <= next_pc;
            halt <= ctrl.halt;                  // sticky until reset.
        end
    end

    // a misaligned jalr or trap vector would show up here.
    pc_word_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- rtl/decoder.sv
`timescale 1ns/1ns
`default_nettype none

module decoder import rv_core_pkg::*; (
    input  wire  [31:0] instr,
    output ctrl_t       ctrl,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    output logic [31:0] imm
);

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011
    } opcode_e;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic        alt;                           // funct7 bit 5, sub and sra.
    alu_op_e     arith_op;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = instr[30];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    always_comb begin
        case (opcode)
            op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
            op_lui,
            op_auipc:  imm = {instr[31:12], 12'b0};
            op_jal:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
            default:   imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // shared by register-register and register-immediate forms.
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == op_reg && alt) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            op_lui: begin
                ctrl.alu_op    = alu_pass_b;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_wen   = 1'b1;
            end
            op_auipc: begin
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_wen   = 1'b1;
            end
            op_imm: begin
                ctrl.alu_op    = arith_op;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_wen   = 1'b1;
            end
            op_reg: begin
                ctrl.alu_op  = arith_op;
                ctrl.reg_wen = 1'b1;
            end
            op_load: begin
                if (funct3 == 3'b010) begin     // lw only.
                    ctrl.src_b_imm = 1'b1;
                    ctrl.mem_ren   = 1'b1;
                    ctrl.reg_wen   = 1'b1;
                    ctrl.wb_sel    = wb_mem;
                end
            end
            op_store: begin
                if (funct3 == 3'b010) begin
                    ctrl.src_b_imm = 1'b1;
                    ctrl.mem_wen   = 1'b1;
                end
            end
            op_branch: begin
                case (funct3)
                    3'b000:  ctrl.branch = br_eq;
                    3'b001:  ctrl.branch = br_ne;
                    3'b100:  ctrl.branch = br_lt;
                    3'b101:  ctrl.branch = br_ge;
                    3'b110:  ctrl.branch = br_ltu;
                    3'b111:  ctrl.branch = br_geu;
                    default: ctrl.branch = br_none;
                endcase
            end
            op_jal, op_jalr: begin
                ctrl.src_a_pc  = (opcode == op_jal);
                ctrl.src_b_imm = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.reg_wen   = 1'b1;
                ctrl.wb_sel    = wb_pc_plus4;
            end
            op_system: begin
                case (funct3)
                    3'b000: begin
                        ctrl.ecall = (imm[11:0] == 12'h000);
                        ctrl.halt  = (imm[11:0] == 12'h001);
                        ctrl.mret  = (imm[11:0] == 12'h302);
                    end
                    3'b001: begin
                        ctrl.csr_op  = csr_write;
                        ctrl.reg_wen = 1'b1;
                        ctrl.wb_sel  = wb_csr;
                    end
                    3'b010: begin
                        ctrl.csr_op  = csr_set;
                        ctrl.reg_wen = 1'b1;
                        ctrl.wb_sel  = wb_csr;
                    end
                    default: ;
                endcase
            end
            default: ;                          // unknown opcode runs as a no-op.
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [4:0]  rs1,
    input  wire  [4:0]  rs2,
    input  wire  [4:0]  rd,
    input  wire         wen,
    input  wire  [31:0] rd_value,
    output logic [31:0] rs1_value,
    output logic [31:0] rs2_value
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (wen && rd != 5'd0) begin
            regs[rd] <= rd_value;
        end
    end

    assign rs1_value = (rs1 == 5'd0) ? 32'd0 : regs[rs1];   // x0 reads as zero.
    assign rs2_value = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

    // the enable is gated upstream in mem_stage.
    no_write_in_reset: assert property (@(posedge clk) !rst_n |-> !wen);

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import rv_core_pkg::*; (
    input  wire ctrl_t  ctrl,
    input  wire  [31:0] pc,
    input  wire  [31:0] imm,
    input  wire  [31:0] rs1_value,
    input  wire  [31:0] rs2_value,
    output logic [31:0] result,
    output logic        taken
);

    logic [31:0] op_a;
    logic [31:0] op_b;

    assign op_a = ctrl.src_a_pc  ? pc  : rs1_value;
    assign op_b = ctrl.src_b_imm ? imm : rs2_value;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:    result = op_a - op_b;
            alu_and:    result = op_a & op_b;
            alu_or:     result = op_a | op_b;
            alu_xor:    result = op_a ^ op_b;
            alu_slt:    result = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   result = {31'd0, op_a < op_b};
            alu_sll:    result = op_a << op_b[4:0];
            alu_srl:    result = op_a >> op_b[4:0];
            alu_sra:    result = $unsigned($signed(op_a) >>> op_b[4:0]);
            alu_pass_b: result = op_b;
            default:    result = op_a + op_b;
        endcase
    end

    // branches always compare the two registers.
    always_comb begin
        case (ctrl.branch)
            br_eq:   taken = (rs1_value == rs2_value);
            br_ne:   taken = (rs1_value != rs2_value);
            br_lt:   taken = ($signed(rs1_value) <  $signed(rs2_value));
            br_ge:   taken = ($signed(rs1_value) >= $signed(rs2_value));
            br_ltu:  taken = (rs1_value <  rs2_value);
            br_geu:  taken = (rs1_value >= rs2_value);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.branch == br_none) begin
            no_taken_without_branch: assert final (!taken);
        end
    end

endmodule

`default_nettype wire

//--- rtl/csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit import rv_core_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire ctrl_t  ctrl,
    input  wire  [31:0] pc,
    input  wire  [11:0] csr_addr,
    input  wire  [31:0] rs1_value,
    input  wire         halted,
    output logic [31:0] csr_rdata,
    output logic [31:0] mepc,
    output logic [31:0] mtvec
);

    logic [31:0] mcause;
    logic [31:0] mstatus;
    logic [31:0] csr_wdata;

    always_comb begin
        case (csr_addr)
            csr_mepc:    csr_rdata = mepc;
            csr_mcause:  csr_rdata = mcause;
            csr_mstatus: csr_rdata = mstatus;
            csr_mtvec:   csr_rdata = mtvec;
            default:     csr_rdata = 32'd0;
        endcase
    end

    // csrrs with rs1 = x0 leaves the value as it was.
    assign csr_wdata = (ctrl.csr_op == csr_set) ? (csr_rdata | rs1_value) : rs1_value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mepc    <= 32'd0;
            mcause  <= 32'd0;
            mstatus <= mstatus_reset;
            mtvec   <= 32'd0;
        end else if (!halted) begin
            if (ctrl.ecall) begin
                mepc   <= pc;                   // handler returns here plus 4.
                mcause <= mcause_ecall;
            end else if (ctrl.csr_op != csr_none) begin
                case (csr_addr)
                    csr_mepc:    mepc    <= csr_wdata;
                    csr_mcause:  mcause  <= csr_wdata;
                    csr_mstatus: mstatus <= csr_wdata;
                    csr_mtvec:   mtvec   <= csr_wdata;
                    default: ;
                endcase
            end
        end
    end

    csr_write_not_with_ecall: assert property (
        @(posedge clk) disable iff (!rst_n) !(ctrl.ecall && ctrl.csr_op != csr_none)
    );

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage import rv_core_pkg::*; (
    input  wire         rst_n,
    input  wire         halted,
    input  wire ctrl_t  ctrl,
    input  wire  [31:0] alu_result,
    input  wire  [31:0] rs2_value,
    input  wire  [31:0] dmem_rdata,
    input  wire  [31:0] csr_rdata,
    input  wire  [31:0] pc,
    output dmem_req_t   dmem_req,
    output logic [31:0] rd_value,
    output logic        reg_wen
);

    logic active;

    assign active = rst_n && !halted;           // nothing retires in reset or halt.

    assign dmem_req.valid = active && (ctrl.mem_ren || ctrl.mem_wen);
    assign dmem_req.wen   = active && ctrl.mem_wen;
    assign dmem_req.addr  = alu_result;         // base plus offset.
    assign dmem_req.wdata = rs2_value;

    assign reg_wen = active && ctrl.reg_wen;

    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:      rd_value = dmem_rdata;
            wb_pc_plus4: rd_value = pc + 32'd4; // link address.
            wb_csr:      rd_value = csr_rdata;
            default:     rd_value = alu_result;
        endcase
    end

    always_comb begin
        if (dmem_req.valid) begin
            dmem_addr_aligned: assert final (dmem_req.addr[1:0] == 2'b00);
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv32_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_core import rv_core_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h8000_0000
) (
    input  wire         clk,
    input  wire         rst_n,
    output logic [31:0] imem_addr,
    input  wire  [31:0] imem_data,
    output dmem_req_t   dmem_req,
    input  wire  [31:0] dmem_rdata,
    output logic        halt
);

    logic [31:0] pc;
    ctrl_t       ctrl;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] alu_result;
    logic        taken;
    logic [31:0] csr_rdata;
    logic [31:0] mepc;
    logic [31:0] mtvec;
    logic [31:0] rd_value;
    logic        reg_wen;

    assign imem_addr = pc;                      // fetch straight from the pc.

    fetch_unit #(
        .reset_pc   (reset_pc)
    ) u_fetch_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .imm        (imm),
        .taken      (taken),
        .alu_result (alu_result),
        .mepc       (mepc),
        .mtvec      (mtvec),
        .pc         (pc),
        .halt       (halt)
    );

    decoder u_decoder (
        .instr (imem_data),
        .ctrl  (ctrl),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .imm   (imm)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .wen       (reg_wen),
        .rd_value  (rd_value),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    alu u_alu (
        .ctrl      (ctrl),
        .pc        (pc),
        .imm       (imm),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .result    (alu_result),
        .taken     (taken)
    );

    csr_unit u_csr_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .pc        (pc),
        .csr_addr  (imm[11:0]),
        .rs1_value (rs1_value),
        .halted    (halt),
        .csr_rdata (csr_rdata),
        .mepc      (mepc),
        .mtvec     (mtvec)
    );

    mem_stage u_mem_stage (
        .rst_n      (rst_n),
        .halted     (halt),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .rs2_value  (rs2_value),
        .dmem_rdata (dmem_rdata),
        .csr_rdata  (csr_rdata),
        .pc         (pc),
        .dmem_req   (dmem_req),
        .rd_value   (rd_value),
        .reg_wen    (reg_wen)
    );

endmodule

`default_nettype wire

//--- dv/tb_rv32_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv32_core import rv_core_pkg::*; ();

    localparam logic [31:0] reset_pc      = 32'h8000_0000;
    localparam logic [31:0] poison_addr   = 32'h0000_00f0;
    localparam logic [31:0] result_base   = 32'h0000_0100;
    localparam int          handler_index = 96;            // trap handler at reset_pc + 0x180.
    localparam int          halt_timeout  = 400;

    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_system = 7'b1110011;

    logic        clk;
    logic        rst_n;
    logic        rst_q;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;
    logic        halt;

    logic [31:0] rom [128];
    logic [31:0] dmem [128];
    logic [31:0] expected [128];
    bit          expected_set [128];
    int          expected_count;
    int          stores_seen;
    int          prog_len;
    logic [31:0] imem_offset;
    logic [31:0] rom_word;
    logic [31:0] probe_store;
    logic        store_now;
    logic        store_in_range;
    logic [6:0]  store_idx;

    rv32_core #(
        .reset_pc   (reset_pc)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .halt       (halt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign imem_offset    = imem_addr - reset_pc;
    assign rom_word       = (imem_offset[31:9] == '0) ? rom[imem_offset[8:2]] : 32'h0000_0013;
    assign imem_data      = rst_n ? rom_word : probe_store;   // a store in reset must stay idle.
    assign store_now      = dmem_req.valid && dmem_req.wen;
    assign store_in_range = (dmem_req.addr[31:9] == '0);
    assign store_idx      = dmem_req.addr[8:2];
    assign dmem_rdata     = dmem[dmem_req.addr[8:2]];

    always @(posedge clk) begin
        rst_q <= rst_n;
        if (store_now && store_in_range) begin
            dmem[store_idx] <= dmem_req.wdata;
            if (expected_set[store_idx]) begin
                stores_seen <= stores_seen + 1;
            end
        end
    end

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return 32'hc0de_0000 | addr;
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] funct7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] funct3, input logic [4:0] rd,
                                          input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opcode);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic emit_poison();
        emit(stype(poison_addr[11:0], 5'd0, 5'd0));
    endtask

    task automatic expect_word(input logic [31:0] addr, input logic [31:0] value);
        expected[addr[8:2]]     = value;
        expected_set[addr[8:2]] = 1'b1;
        expected_count++;
    endtask

    task automatic store_result(input int slot, input logic [4:0] rs2, input logic [31:0] value);
        logic [31:0] addr;
        addr = result_base + 32'(slot * 4);
        emit(stype(addr[11:0], rs2, 5'd0));
        expect_word(addr, value);
    endtask

    task automatic taken_branch(input logic [2:0] funct3, input logic [4:0] rs1,
                                input logic [4:0] rs2);
        emit(btype(13'd8, rs2, rs1, funct3));
        emit_poison();
    endtask

    // a wrongly taken branch lands on the poison store.
    task automatic untaken_branch(input logic [2:0] funct3, input logic [4:0] rs1,
                                  input logic [4:0] rs2);
        emit(btype(13'd8, rs2, rs1, funct3));
        emit(jtype(21'd8, 5'd0));
        emit_poison();
    endtask

    task automatic build_program();
        logic signed [31:0] a;
        logic signed [31:0] b;
        logic [31:0]        mark_pc;
        a = -32'sd7;
        b = 32'sd5;
        for (int k = 0; k < 128; k++) begin
            rom[k]          = 32'h0000_0013;
            dmem[k]         = fill_word(32'(k * 4));
            expected_set[k] = 1'b0;
        end
        probe_store = stype(12'h080, 5'd1, 5'd0);
        prog_len = 0;
        emit(itype(a[11:0], 5'd0, 3'b000, 5'd1, opc_imm));
        emit(itype(b[11:0], 5'd0, 3'b000, 5'd2, opc_imm));
        emit(utype(20'h12345, 5'd3, opc_lui));
        store_result(0, 5'd3, 32'h1234_5000);
        mark_pc = reset_pc + 32'(4 * prog_len);
        emit(utype(20'h00001, 5'd4, opc_auipc));
        store_result(1, 5'd4, mark_pc + 32'h0000_1000);
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
        emit(rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd6));
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b111, 5'd7));
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b110, 5'd8));
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b100, 5'd9));
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b010, 5'd11));
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b011, 5'd12));
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b001, 5'd13));
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b101, 5'd14));
        emit(rtype(7'h20, 5'd2, 5'd1, 3'b101, 5'd15));
        emit(itype(12'hff8, 5'd1, 3'b010, 5'd16, opc_imm));     // slti against -8.
        emit(itype(12'h0f0, 5'd2, 3'b100, 5'd17, opc_imm));
        emit(itype(12'h401, 5'd1, 3'b101, 5'd18, opc_imm));     // srai by 1.
        emit(itype(12'h0ff, 5'd1, 3'b111, 5'd19, opc_imm));
        store_result(2, 5'd5, a + b);
        store_result(3, 5'd6, a - b);
        store_result(4, 5'd7, a & b);
        store_result(5, 5'd8, a | b);
        store_result(6, 5'd9, a ^ b);
        store_result(7, 5'd11, {31'd0, a < b});
        store_result(8, 5'd12, {31'd0, $unsigned(a) < $unsigned(b)});
        store_result(9, 5'd13, a << b[4:0]);
        store_result(10, 5'd14, $unsigned(a) >> b[4:0]);
        store_result(11, 5'd15, a >>> b[4:0]);
        store_result(12, 5'd16, {31'd0, a < -32'sd8});
        store_result(13, 5'd17, b ^ 32'h0000_00f0);
        store_result(14, 5'd18, a >>> 1);
        store_result(15, 5'd19, a & 32'h0000_00ff);
        emit(itype(12'h040, 5'd0, 3'b010, 5'd20, opc_load));
        emit(itype(12'h044, 5'd0, 3'b010, 5'd21, opc_load));
        emit(itype(12'h123, 5'd20, 3'b000, 5'd20, opc_imm));
        emit(itype(12'hfff, 5'd21, 3'b100, 5'd21, opc_imm));    // xori with -1 inverts.
        emit(stype(12'h040, 5'd20, 5'd0));
        emit(stype(12'h044, 5'd21, 5'd0));
        expect_word(32'h0000_0040, fill_word(32'h0000_0040) + 32'h123);
        expect_word(32'h0000_0044, ~fill_word(32'h0000_0044));
        taken_branch(3'b000, 5'd2, 5'd2);
        taken_branch(3'b001, 5'd1, 5'd2);
        taken_branch(3'b100, 5'd1, 5'd2);
        taken_branch(3'b101, 5'd2, 5'd1);
        taken_branch(3'b110, 5'd2, 5'd1);
        taken_branch(3'b111, 5'd1, 5'd2);
        untaken_branch(3'b000, 5'd1, 5'd2);
        untaken_branch(3'b001, 5'd2, 5'd2);
        untaken_branch(3'b100, 5'd2, 5'd1);
        untaken_branch(3'b101, 5'd1, 5'd2);
        untaken_branch(3'b110, 5'd1, 5'd2);
        untaken_branch(3'b111, 5'd2, 5'd1);
        mark_pc = reset_pc + 32'(4 * prog_len);
        emit(jtype(21'd8, 5'd22));
        emit_poison();
        store_result(16, 5'd22, mark_pc + 32'd4);
        mark_pc = reset_pc + 32'(4 * prog_len);
        emit(utype(20'h00000, 5'd23, opc_auipc));
        emit(itype(12'd12, 5'd23, 3'b000, 5'd24, opc_jalr));   // lands past the poison.
        emit_poison();
        store_result(17, 5'd24, mark_pc + 32'd8);
        emit(utype(20'h80000, 5'd25, opc_lui));
        emit(itype(12'(handler_index * 4), 5'd25, 3'b000, 5'd25, opc_imm));
        emit(itype(12'h305, 5'd25, 3'b001, 5'd0, opc_system)); // csrrw mtvec.
        emit(itype(12'h5a5, 5'd0, 3'b000, 5'd28, opc_imm));
        mark_pc = reset_pc + 32'(4 * prog_len);
        emit(itype(12'h000, 5'd0, 3'b000, 5'd0, opc_system));  // ecall.
        store_result(20, 5'd28, 32'h0000_05a5);
        emit(itype(12'h300, 5'd0, 3'b010, 5'd29, opc_system)); // csrrs mstatus.
        store_result(21, 5'd29, 32'h0000_1800);
        emit(itype(12'h001, 5'd0, 3'b000, 5'd0, opc_system));  // ebreak.
        emit_poison();
        prog_len = handler_index;
        emit(itype(12'h342, 5'd0, 3'b010, 5'd26, opc_system));
        store_result(18, 5'd26, 32'd11);
        emit(itype(12'h341, 5'd0, 3'b010, 5'd27, opc_system));
        store_result(19, 5'd27, mark_pc);
        emit(itype(12'h004, 5'd27, 3'b000, 5'd27, opc_imm));
        emit(itype(12'h341, 5'd27, 3'b001, 5'd0, opc_system));
        emit(itype(12'h302, 5'd0, 3'b000, 5'd0, opc_system));  // mret.
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    reset_pc_held: assert property (@(negedge clk) !rst_q |-> imem_addr == reset_pc)
        else stop_on_error($sformatf("Fail imem_addr %h expected %h",
                                     $sampled(imem_addr), reset_pc));

    reset_quiet: assert property (@(negedge clk) !rst_q |-> !dmem_req.valid && !halt)
        else stop_on_error($sformatf("Fail dmem_req.valid %h halt %h expected 0 and 0",
                                     $sampled(dmem_req.valid), $sampled(halt)));

    result_value: assert property (@(posedge clk) disable iff (!rst_n)
        store_now && store_in_range && expected_set[store_idx]
            |-> dmem_req.wdata == expected[store_idx])
        else stop_on_error($sformatf("Fail dmem_req.wdata %h expected %h at address %h",
                                     $sampled(dmem_req.wdata), expected[$sampled(store_idx)],
                                     $sampled(dmem_req.addr)));

    poison_untouched: assert property (@(posedge clk) disable iff (!rst_n)
        store_now |-> dmem_req.addr != poison_addr)
        else stop_on_error("a store hit the poison address on a path that must be skipped");

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
        else stop_on_error("Fail halt 0 expected 1 once raised");

    halt_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        halt |=> $stable(imem_addr))
        else stop_on_error($sformatf("Fail imem_addr %h changed while halted",
                                     $sampled(imem_addr)));

    halt_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        halt |-> !dmem_req.valid)
        else stop_on_error("Fail dmem_req.valid 1 expected 0 while halted");

    initial begin
        int cycles;
        rst_n          = 1'b0;
        expected_count = 0;
        stores_seen    = 0;
        build_program();
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;
        cycles = 0;
        while (!halt && cycles < halt_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt) begin
            stop_on_error("halt did not rise before the timeout");
        end else begin
            @(posedge clk);
            #2 rom[imem_offset[8:2]] = probe_store;     // the parked pc now sees a live store.
            for (int n = 0; n < 20; n++) begin
                @(negedge clk);                         // halt checks run meanwhile.
            end
            if (stores_seen != expected_count) begin
                stop_on_error($sformatf("only %0d of %0d result stores were seen",
                                        stores_seen, expected_count));
            end else begin
                $display("*** PASSED ***");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

//--- compile.f
rtl/rv_core_pkg.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/csr_unit.sv
rtl/mem_stage.sv
rtl/rv32_core.sv
dv/tb_rv32_core.sv

//--- Bender.yml
package:
  name: rv32_core

sources:
  - rtl/rv_core_pkg.sv
  - rtl/fetch_unit.sv
  - rtl/decoder.sv
  - rtl/reg_file.sv
  - rtl/alu.sv
  - rtl/csr_unit.sv
  - rtl/mem_stage.sv
  - rtl/rv32_core.sv
  - target: test
    files:
      - dv/tb_rv32_core.sv
